/* Bender.yml */
package:
  name: ice51

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ice51_pkg.sv
      - hdl/ice51_uart_loader.sv
      - hdl/ice51_uart_tx.sv
      - hdl/ice51_sequencer.sv
      - hdl/ice51_datapath.sv
      - hdl/ice51_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/tb_clock.sv
      - bench/tb_ice51.sv

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
   output logic o_clk,
   output logic o_nrst
);

   initial begin
      o_clk = 1'b0;
      forever #4 o_clk = ~o_clk;   // 8 ns period
   end

   // reset held low for two rising edges
   initial begin
      o_nrst = 1'b0;
      repeat (2) @(posedge o_clk);
      #2 o_nrst = 1'b1;
   end

endmodule

/* bench/tb_ice51.sv */
`timescale 1ns/1ps
`include "ice51_config.svh"

module tb_ice51;
   import ice51_pkg::*;

   localparam int BIT_T = `ICE_BIT_CLKS + 1;    // clocks per uart bit
   localparam int NBYTE = `ICE_LOAD_BYTES;

   logic        clk;
   logic        nrst;
   logic        uart_rx;
   logic        uart_tx;
   logic        code_wr;
   code_addr_t  code_addr;
   byte_t       code_wdata;
   byte_t       code_rdata;
   byte_t       mem [NBYTE];
   byte_t       image [NBYTE];
   logic [31:0] lfsr;
   int          pc_b;
   int          cur_test;
   byte_t       m_a;                   // reference accumulator
   logic        m_c;
   byte_t       m_r [8];
   byte_t       exp_q [$];
   int          tag_q [$];
   int          test_left [7];
   int          test_err [7];
   string       test_name [7];
   int          errors;
   int          wr_cnt;
   logic        pc_grab;
   logic        mon_done;

   tb_clock u_clk (.o_clk(clk), .o_nrst(nrst));

   ice51_top uut (
      .i_clk       (clk),
      .i_nrst      (nrst),
      .i_uart_rx   (uart_rx),
      .o_uart_tx   (uart_tx),
      .o_code_wr   (code_wr),
      .o_code_addr (code_addr),
      .o_code_data (code_wdata),
      .i_code_data (code_rdata)
   );

   // synchronous code memory with one cycle of read latency
   always @(posedge clk) begin
      if (code_wr) mem[code_addr] <= code_wdata;
      code_rdata <= mem[code_addr];
   end

   //////////////////////////////////////////////////
   // random bytes and the program builder

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic rand_byte(output byte_t v);
      for (int i = 0; i < 8; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[6:0], lfsr[0]};
      end
   endtask

   task automatic emit(input byte_t b);
      if (pc_b < NBYTE) image[pc_b] = b;
      pc_b++;
   endtask

   task automatic expect_byte(input byte_t v);
      exp_q.push_back(v);
      tag_q.push_back(cur_test);
      test_left[cur_test]++;
   endtask

   task automatic mov_a_imm(input byte_t v);
      emit(8'h74);
      emit(v);
      m_a = v;
   endtask

   task automatic add_imm(input byte_t v);
      emit(8'h24);
      emit(v);
      m_a = m_a + v;
   endtask

   task automatic subb_imm(input byte_t v);
      int diff;
      emit(8'h94);
      emit(v);
      diff = int'(m_a) - int'(v) - int'(m_c);
      m_a  = byte_t'(diff);
      m_c  = (diff < 0);               // borrow
   endtask

   task automatic xrl_imm(input byte_t v);
      emit(8'h64);
      emit(v);
      m_a = m_a ^ v;
   endtask

   task automatic dec_acc();
      emit(8'h14);
      m_a = m_a - 8'd1;
   endtask

   task automatic clr_acc();
      emit(8'he4);
      m_a = 8'd0;
   endtask

   task automatic clr_carry();
      emit(8'hc3);
      m_c = 1'b0;
   endtask

   task automatic mov_reg_imm(input int n, input byte_t v);
      emit(8'h78 | byte_t'(n));
      emit(v);
      m_r[n] = v;
   endtask

   task automatic mov_reg_acc(input int n);
      emit(8'hf8 | byte_t'(n));
      m_r[n] = m_a;
   endtask

   task automatic mov_acc_reg(input int n);
      emit(8'he8 | byte_t'(n));
      m_a = m_r[n];
   endtask

   task automatic inc_reg(input int n);
      emit(8'h08 | byte_t'(n));
      m_r[n] = m_r[n] + 8'd1;
   endtask

   task automatic mov_dptr_imm(input dptr_t a);
      emit(8'h90);
      emit(a[15:8]);
      emit(a[7:0]);
   endtask

   task automatic branch(input byte_t opc, input byte_t off);
      emit(opc);
      emit(off);
   endtask

   task automatic trap();
      branch(8'h80, 8'hfe);            // sjmp to itself
   endtask

   // save a in r7, poll 0200 until idle, then write a to 0201
   task automatic send_polled();
      mov_reg_acc(7);
      mov_dptr_imm(`ICE_TX_STAT_ADDR);
      emit(8'he0);                     // movx a,@dptr
      emit(8'hc3);
      emit(8'h94);                     // subb a,#1
      emit(8'h01);
      branch(8'h50, 8'hfa);            // jnc back to movx while busy
      mov_dptr_imm(`ICE_TX_DATA_ADDR);
      emit(8'hef);
      emit(8'hf0);
      m_a = m_r[7];
      m_c = 1'b1;
      expect_byte(m_a);
   endtask

   task automatic build_image();
      byte_t v;
      byte_t w;
      int    p;
      int    d;
      int    s2;
      int    c;
      for (int i = 0; i < NBYTE; i++) image[i] = byte_t'(i) ^ {i[8], 7'h5a};
      pc_b = `ICE_RESET_PC;
      m_a  = 8'd0;
      m_c  = 1'b0;

      // tx is still idle so the first byte needs no poll
      cur_test = 2;
      rand_byte(v);
      mov_a_imm(v);
      mov_dptr_imm(`ICE_TX_DATA_ADDR);
      emit(8'hf0);
      expect_byte(v);

      cur_test = 3;
      rand_byte(v);
      mov_a_imm(v);
      rand_byte(v);
      add_imm(v);
      send_polled();
      clr_carry();
      rand_byte(v);
      subb_imm(v);
      send_polled();
      rand_byte(v);
      mov_a_imm(v & 8'h3f);
      clr_carry();
      rand_byte(v);
      subb_imm(v | 8'h80);             // forces a borrow
      rand_byte(v);
      subb_imm(v);
      send_polled();
      rand_byte(v);
      xrl_imm(v);
      send_polled();
      dec_acc();
      send_polled();
      clr_acc();
      dec_acc();
      send_polled();

      cur_test = 4;
      for (int n = 0; n < 8; n++) begin
         rand_byte(v);
         mov_reg_imm(n, v);
      end
      rand_byte(v);
      mov_a_imm(v);
      mov_reg_acc(3);
      inc_reg(5);
      inc_reg(3);
      // r7 goes first since every send overwrites it
      for (int n = 7; n >= 0; n--) begin
         mov_acc_reg(n);
         send_polled();
      end

      cur_test = 5;
      emit(8'h02);
      w = byte_t'(pc_b + 4);
      emit(byte_t'((pc_b + 4) >> 8));
      emit(w);
      trap();
      branch(8'h80, 8'h02);
      trap();
      mov_a_imm(8'ha1);
      send_polled();
      p = pc_b;                        // sjmp forward then back into the block
      branch(8'h80, 8'h00);
      d = pc_b;
      mov_a_imm(8'ha2);
      send_polled();
      s2 = pc_b;
      branch(8'h80, 8'h00);
      c = pc_b;
      branch(8'h80, byte_t'(d - (c + 2)));
      image[p + 1]  = byte_t'(c - (p + 2));
      image[s2 + 1] = byte_t'(pc_b - (s2 + 2));
      branch(8'h50, 8'h02);            // jnc falls through with carry set
      branch(8'h80, 8'h02);
      trap();
      branch(8'h40, 8'h02);            // jc taken
      trap();
      clr_carry();
      branch(8'h50, 8'h02);            // jnc taken
      trap();
      branch(8'h40, 8'h02);            // jc falls through
      branch(8'h80, 8'h02);
      trap();
      mov_a_imm(8'ha3);
      send_polled();

      cur_test = 6;
      for (int i = 0; i < 4; i++) begin
         rand_byte(v);
         mov_a_imm(v);
         send_polled();
      end
      trap();
   endtask

   //////////////////////////////////////////////////
   // uart driver and boot checks

   task automatic drive_byte(input byte_t b);
      logic [9:0] frame;
      frame = {1'b1, b, 1'b0};         // lsb first on the wire
      for (int i = 0; i < 10; i++) begin
         @(posedge clk);
         #2 uart_rx = frame[i];
         repeat (BIT_T - 1) @(posedge clk);
      end
   endtask

   always @(negedge clk) begin
      if (pc_grab) begin
         pc_grab = 1'b0;
         assert (code_addr == code_addr_t'(`ICE_RESET_PC))
         else begin
            $display("[ERROR] %0t first fetch address %0d", $time, code_addr);
            errors++;
         end
      end
      if (nrst && code_wr) begin
         assert (code_addr == code_addr_t'(wr_cnt) && code_wdata == image[wr_cnt])
         else begin
            $display("[ERROR] %0t boot write %0d: addr %0d data %h, expected data %h",
                     $time, wr_cnt, code_addr, code_wdata, image[wr_cnt]);
            errors++;
         end
         wr_cnt++;
         if (wr_cnt == NBYTE) pc_grab = 1'b1;   // fetch starts next cycle
      end
   end

   //////////////////////////////////////////////////
   // uart monitor

   initial begin
      byte_t got;
      int    tag;
      int    wait_cnt;
      mon_done = 1'b0;
      wait_cnt = 0;
      // the program starts sending right after the last boot write
      while (wr_cnt < NBYTE && wait_cnt < 1_000_000) begin
         @(negedge clk);
         wait_cnt++;
      end
      while (exp_q.size() > 0) begin
         wait_cnt = 0;
         while (uart_tx && wait_cnt < 40 * BIT_T) begin
            @(negedge clk);
            wait_cnt++;
         end
         if (uart_tx) begin
            $display("monitor: no start bit seen, %0d bytes never arrived", exp_q.size());
            errors++;
            break;
         end
         repeat (BIT_T / 2) @(negedge clk);
         assert (uart_tx == 1'b0)
         else begin
            $display("[ERROR] %0t start bit not low at mid-bit", $time);
            errors++;
         end
         for (int b = 7; b >= 0; b--) begin
            repeat (BIT_T) @(negedge clk);
            got[b] = uart_tx;
         end
         repeat (BIT_T) @(negedge clk);
         tag = tag_q.pop_front();
         assert (uart_tx == 1'b1 && got == exp_q[0])
         else begin
            $display("[ERROR] %0t test %0d: byte %h stop %b, expected %h",
                     $time, tag, got, uart_tx, exp_q[0]);
            errors++;
            test_err[tag]++;
         end
         void'(exp_q.pop_front());
         test_left[tag]--;
         if (test_left[tag] == 0)
            $display("test %0d %s finished, %0d mismatches", tag, test_name[tag],
                     test_err[tag]);
      end
      mon_done = 1'b1;
   end

   //////////////////////////////////////////////////
   // main sequence

   initial begin
      int wait_cnt;
      uart_rx    = 1'b1;
      code_rdata = 8'd0;
      errors     = 0;
      wr_cnt     = 0;
      pc_grab    = 1'b0;
      lfsr       = 32'hbb64ba69;
      test_name  = '{"", "boot load", "tx framing", "arithmetic", "registers",
                     "branches", "busy polling"};
      build_image();
      assert (pc_b <= NBYTE)
      else begin
         $display("program image does not fit in code memory (%0d bytes)", pc_b);
         errors++;
      end

      wait_cnt = 0;
      while (!nrst && wait_cnt < 20) begin
         @(posedge clk);
         wait_cnt++;
      end
      for (int i = 0; i < NBYTE; i++) drive_byte(image[i]);

      wait_cnt = 0;
      while (wr_cnt < NBYTE && wait_cnt < 4 * BIT_T) begin
         @(posedge clk);
         wait_cnt++;
      end
      if (wr_cnt < NBYTE) begin
         $display("boot load stopped after %0d of %0d writes", wr_cnt, NBYTE);
         errors++;
      end
      @(negedge clk);
      $display("test 1 %s finished, %0d writes", test_name[1], wr_cnt);

      wait_cnt = 0;
      while (!mon_done && wait_cnt < 200_000) begin
         @(negedge clk);
         wait_cnt++;
      end
      if (!mon_done) begin
         $display("timed out waiting for the transmitted bytes");
         errors++;
      end

      // program ends in a trap so the line stays quiet
      for (int i = 0; i < 20 * BIT_T; i++) begin
         @(negedge clk);
         assert (uart_tx == 1'b1)
         else begin
            $display("[ERROR] %0t unexpected frame after the last byte", $time);
            errors++;
            break;
         end
      end

      $display("checks done: %0d bytes loaded, %0d errors", wr_cnt, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

/* hdl/ice51_config.svh */
`ifndef ICE51_CONFIG_SVH
`define ICE51_CONFIG_SVH

//////////////////////////////////////////////////
// uart timing

// clocks per bit are ICE_BIT_CLKS + 1
`define ICE_BIT_CLKS       104

//////////////////////////////////////////////////
// boot and memory map

`define ICE_LOAD_BYTES     512         // boot image size in bytes
`define ICE_RESET_PC       3           // first opcode after boot

// movx targets of the transmitter
`define ICE_TX_DATA_ADDR   16'h0201
`define ICE_TX_STAT_ADDR   16'h0200

`endif

/* hdl/ice51_datapath.sv */
`timescale 1ns/1ps
`include "ice51_config.svh"

module ice51_datapath (
   input  logic             i_clk,
   input  logic             i_nrst,
   input  ice51_pkg::exec_t i_exec,
   input  logic             i_exec_en,
   input  logic             i_tx_busy,
   output logic             o_carry,
   output logic             o_tx_start,
   output ice51_pkg::byte_t o_tx_byte
);
   import ice51_pkg::*;

   byte_t      acc;
   byte_t      acc_n;
   logic       carry_n;
   byte_t      regs [8];
   byte_t      r_sel;
   byte_t      imm;
   dptr_t      dptr;
   logic [8:0] sub_wide;           // bit 8 is the borrow

   assign imm   = i_exec.imm_hi;
   assign r_sel = regs[i_exec.rn];

   //////////////////////////////////////////////////
   // accumulator and carry

   assign sub_wide = {1'b0, acc} - {1'b0, imm} - {8'd0, o_carry};

   always_comb begin
      acc_n   = acc;
      carry_n = o_carry;
      case (i_exec.kind)
         k_mov_ai:  acc_n = imm;
         k_add_ai:  acc_n = acc + imm;   // carry untouched
         k_subb_ai: begin
            acc_n   = sub_wide[7:0];
            carry_n = sub_wide[8];
         end
         k_xrl_ai:  acc_n = acc ^ imm;
         k_dec_a:   acc_n = acc - 8'd1;
         k_clr_a:   acc_n = 8'd0;
         k_clr_c:   carry_n = 1'b0;
         k_mov_ar:  acc_n = r_sel;
         k_movx_ad: if (dptr == `ICE_TX_STAT_ADDR) acc_n = {7'd0, i_tx_busy};
         default:   ;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc     <= '0;
         o_carry <= 1'b0;
         dptr    <= '0;
      end else if (i_exec_en) begin
         acc     <= acc_n;
         o_carry <= carry_n;
         if (i_exec.kind == k_mov_dptr) dptr <= {i_exec.imm_hi, i_exec.imm_lo};
      end
   end

   //////////////////////////////////////////////////
   // r0..r7

   always_ff @(posedge i_clk) begin
      if (i_exec_en) begin
         case (i_exec.kind)
            k_mov_ra: regs[i_exec.rn] <= acc;
            k_mov_ri: regs[i_exec.rn] <= imm;
            k_inc_r:  regs[i_exec.rn] <= r_sel + 8'd1;
            default:  ;
         endcase
      end
   end

   //////////////////////////////////////////////////
   // transmitter access

   // software polls busy first, a start while busy is dropped by the tx
   assign o_tx_start = i_exec_en && (i_exec.kind == k_movx_da) &&
                       (dptr == `ICE_TX_DATA_ADDR);
   assign o_tx_byte  = acc;

endmodule

/* hdl/ice51_pkg.sv */
package ice51_pkg;

   //////////////////////////////////////////////////
   // vectors

   typedef logic [7:0]  byte_t;
   typedef logic [8:0]  code_addr_t;       // 512 byte code space
   typedef logic [15:0] dptr_t;
   typedef logic [2:0]  reg_idx_t;         // r0..r7
   typedef logic [3:0]  bit_cnt_t;         // uart bits in a frame

   //////////////////////////////////////////////////
   // state machines

   typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

   typedef enum logic [1:0] {tx_idle, tx_start, tx_send} tx_state_e;

   typedef enum logic [2:0] {
      st_fetch, st_decode0, st_decode1, st_decode2, st_execute
   } cpu_state_e;

   // one entry per supported opcode, k_nop for the rest
   typedef enum logic [4:0] {
      k_nop,
      k_ljmp, k_sjmp, k_jc, k_jnc,
      k_mov_ai, k_add_ai, k_subb_ai, k_xrl_ai,
      k_dec_a, k_clr_a, k_clr_c,
      k_mov_ra, k_mov_ar, k_mov_ri, k_inc_r,
      k_mov_dptr, k_movx_da, k_movx_ad
   } instr_kind_e;

   // decoded instruction as seen in the execute state
   // a 2-byte instruction carries its operand in imm_hi
   typedef struct packed {
      instr_kind_e kind;
      reg_idx_t    rn;
      byte_t       imm_hi;
      byte_t       imm_lo;
   } exec_t;

endpackage

/* hdl/ice51_sequencer.sv */
`timescale 1ns/1ps
`include "ice51_config.svh"

module ice51_sequencer (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_load_done,
   input  ice51_pkg::byte_t      i_code_data,
   input  logic                  i_carry,
   output ice51_pkg::code_addr_t o_pc,
   output ice51_pkg::exec_t      o_exec,
   output logic                  o_exec_en
);
   import ice51_pkg::*;

   cpu_state_e  state;
   cpu_state_e  state_n;
   code_addr_t  pc;
   byte_t       op;
   byte_t       op_q;
   byte_t       imm_hi_q;
   byte_t       imm_lo_q;
   instr_kind_e kind;
   logic [1:0]  instr_len;         // bytes, 1 to 3
   logic        take_abs;
   logic        take_rel;

   // opcode straight from memory in decode0, latched afterwards
   assign op = (state == st_decode0) ? i_code_data : op_q;

   //////////////////////////////////////////////////
   // decode

   always_comb begin
      kind      = k_nop;
      instr_len = 2'd1;
      casez (op)
         8'h02:       begin kind = k_ljmp;     instr_len = 2'd3; end
         8'b0000_1???:       kind = k_inc_r;
         8'h14:              kind = k_dec_a;
         8'h24:       begin kind = k_add_ai;   instr_len = 2'd2; end
         8'h40:       begin kind = k_jc;       instr_len = 2'd2; end
         8'h50:       begin kind = k_jnc;      instr_len = 2'd2; end
         8'h64:       begin kind = k_xrl_ai;   instr_len = 2'd2; end
         8'h74:       begin kind = k_mov_ai;   instr_len = 2'd2; end
         8'b0111_1???: begin kind = k_mov_ri;  instr_len = 2'd2; end
         8'h80:       begin kind = k_sjmp;     instr_len = 2'd2; end
         8'h90:       begin kind = k_mov_dptr; instr_len = 2'd3; end
         8'h94:       begin kind = k_subb_ai;  instr_len = 2'd2; end
         8'hc3:              kind = k_clr_c;
         8'he0:              kind = k_movx_ad;
         8'he4:              kind = k_clr_a;
         8'b1110_1???:       kind = k_mov_ar;
         8'hf0:              kind = k_movx_da;
         8'b1111_1???:       kind = k_mov_ra;
         default:            kind = k_nop;
      endcase
   end

   //////////////////////////////////////////////////
   // state

   always_comb begin
      state_n = state;
      case (state)
         st_fetch:   if (i_load_done) state_n = st_decode0;
         st_decode0: state_n = (instr_len == 2'd1) ? st_execute : st_decode1;
         st_decode1: state_n = (instr_len == 2'd3) ? st_decode2 : st_execute;
         st_decode2: state_n = st_execute;
         st_execute: state_n = st_fetch;
         default:    state_n = st_fetch;
      endcase
   end

   // only the sequencer looks at the carry for branches
   assign take_abs = (kind == k_ljmp);
   assign take_rel = (kind == k_sjmp) ||
                     (kind == k_jc  &&  i_carry) ||
                     (kind == k_jnc && !i_carry);

   //////////////////////////////////////////////////
   // pc and latches

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= st_fetch;
         pc    <= code_addr_t'(`ICE_RESET_PC);
         op_q  <= '0;
      end else begin
         state <= state_n;
         case (state)
            st_fetch:   if (i_load_done) pc <= pc + 1'b1;
            st_decode0: begin
               op_q <= i_code_data;
               if (instr_len != 2'd1) pc <= pc + 1'b1;
            end
            st_decode1: if (instr_len == 2'd3) pc <= pc + 1'b1;
            st_execute: begin
               // pc already points past the instruction here
               if (take_abs)      pc <= {imm_hi_q[0], imm_lo_q};
               else if (take_rel) pc <= pc + {imm_hi_q[7], imm_hi_q};
            end
            default: ;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state == st_decode1) imm_hi_q <= i_code_data;
      if (state == st_decode2) imm_lo_q <= i_code_data;
   end

   assign o_pc      = pc;
   assign o_exec_en = (state == st_execute);
   assign o_exec    = '{kind: kind, rn: op[2:0], imm_hi: imm_hi_q, imm_lo: imm_lo_q};

endmodule

/* hdl/ice51_top.sv */
`timescale 1ns/1ps

module ice51_top (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_uart_rx,
   output logic                  o_uart_tx,
   output logic                  o_code_wr,
   output ice51_pkg::code_addr_t o_code_addr,
   output ice51_pkg::byte_t      o_code_data,
   input  ice51_pkg::byte_t      i_code_data
);
   import ice51_pkg::*;

   code_addr_t load_addr;
   code_addr_t pc;
   logic       load_done;
   exec_t      exec;
   logic       exec_en;
   logic       carry;
   logic       tx_strobe;
   logic       tx_busy;
   byte_t      tx_byte;

   // loader owns the code bus until the image is in
   assign o_code_addr = load_done ? pc : load_addr;

   ice51_uart_loader u_loader (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_rx        (i_uart_rx),
      .o_code_wr   (o_code_wr),
      .o_code_data (o_code_data),
      .o_load_addr (load_addr),
      .o_load_done (load_done)
   );

   ice51_sequencer u_seq (
      .i_clk       (i_clk),
      .i_nrst      (i_nrst),
      .i_load_done (load_done),
      .i_code_data (i_code_data),
      .i_carry     (carry),
      .o_pc        (pc),
      .o_exec      (exec),
      .o_exec_en   (exec_en)
   );

   ice51_datapath u_dp (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_exec     (exec),
      .i_exec_en  (exec_en),
      .i_tx_busy  (tx_busy),
      .o_carry    (carry),
      .o_tx_start (tx_strobe),
      .o_tx_byte  (tx_byte)
   );

   ice51_uart_tx u_tx (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_tx_start (tx_strobe),
      .i_tx_byte  (tx_byte),
      .o_tx       (o_uart_tx),
      .o_tx_busy  (tx_busy)
   );

endmodule

/* hdl/ice51_uart_loader.sv */
`timescale 1ns/1ps
`include "ice51_config.svh"

module ice51_uart_loader (
   input  logic                  i_clk,
   input  logic                  i_nrst,
   input  logic                  i_rx,
   output logic                  o_code_wr,
   output ice51_pkg::byte_t      o_code_data,
   output ice51_pkg::code_addr_t o_load_addr,
   output logic                  o_load_done
);
   import ice51_pkg::*;

   localparam int               CNT_W = $clog2(`ICE_BIT_CLKS + 1);
   localparam logic [CNT_W-1:0] FULL  = CNT_W'(`ICE_BIT_CLKS);
   localparam logic [CNT_W-1:0] HALF  = CNT_W'(`ICE_BIT_CLKS / 2);

   logic [1:0]       rx_sync;
   logic             rx_in;
   rx_state_e        state;
   logic [CNT_W-1:0] clk_cnt;
   bit_cnt_t         bit_cnt;
   byte_t            rx_shift;
   logic             full_tick;
   logic             half_tick;

   //////////////////////////////////////////////////
   // receive line

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) rx_sync <= 2'b11;        // line idles high
      else         rx_sync <= {rx_sync[0], i_rx};
   end

   assign rx_in     = rx_sync[1];
   assign full_tick = (clk_cnt == FULL);
   assign half_tick = (clk_cnt == HALF);

   //////////////////////////////////////////////////
   // frame FSM

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state     <= rx_idle;
         clk_cnt   <= '0;
         bit_cnt   <= '0;
         o_code_wr <= 1'b0;
      end else begin
         o_code_wr <= 1'b0;
         clk_cnt   <= clk_cnt + 1'b1;
         case (state)
            rx_idle: begin
               clk_cnt <= '0;
               if (!rx_in) state <= rx_start;
            end
            rx_start: if (half_tick) begin
               // centre of start bit, rephase the counter here
               clk_cnt <= '0;
               bit_cnt <= '0;
               state   <= rx_in ? rx_idle : rx_data;   // glitch goes back to idle
            end
            rx_data: if (full_tick) begin
               clk_cnt <= '0;
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == 4'd7) state <= rx_stop;
            end
            rx_stop: if (full_tick) begin
               clk_cnt   <= '0;
               o_code_wr <= ~o_load_done;   // mid stop bit
               state     <= rx_idle;
            end
            default: state <= rx_idle;
         endcase
      end
   end

   // data bits arrive lsb first
   always_ff @(posedge i_clk) begin
      if (state == rx_data && full_tick) rx_shift <= {rx_in, rx_shift[7:1]};
   end

   assign o_code_data = rx_shift;

   //////////////////////////////////////////////////
   // boot counter

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_load_addr <= '0;
         o_load_done <= 1'b0;
      end else if (o_code_wr) begin
         o_load_addr <= o_load_addr + 1'b1;
         if (o_load_addr == code_addr_t'(`ICE_LOAD_BYTES - 1)) o_load_done <= 1'b1;
      end
   end

endmodule

/* hdl/ice51_uart_tx.sv */
`timescale 1ns/1ps
`include "ice51_config.svh"

module ice51_uart_tx (
   input  logic             i_clk,
   input  logic             i_nrst,
   input  logic             i_tx_start,
   input  ice51_pkg::byte_t i_tx_byte,
   output logic             o_tx,
   output logic             o_tx_busy
);
   import ice51_pkg::*;

   localparam int               CNT_W = $clog2(`ICE_BIT_CLKS + 1);
   localparam logic [CNT_W-1:0] FULL  = CNT_W'(`ICE_BIT_CLKS);

   tx_state_e        state;
   logic [CNT_W-1:0] clk_cnt;
   bit_cnt_t         bit_cnt;
   byte_t            tx_shift;
   logic             bit_tick;

   assign bit_tick = (clk_cnt == FULL);

   //////////////////////////////////////////////////
   // frame FSM

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= tx_idle;
         clk_cnt <= '0;
         bit_cnt <= '0;
      end else begin
         clk_cnt <= bit_tick ? '0 : clk_cnt + 1'b1;
         case (state)
            tx_idle: begin
               clk_cnt <= '0;
               bit_cnt <= '0;
               if (i_tx_start) state <= tx_start;   // ignored while busy
            end
            tx_start: if (bit_tick) state <= tx_send;
            tx_send: if (bit_tick) begin
               // 8 data bits, then the filled ones form the stop bit
               bit_cnt <= bit_cnt + 1'b1;
               if (bit_cnt == 4'd8) state <= tx_idle;
            end
            default: state <= tx_idle;
         endcase
      end
   end

   // msb goes out first
   always_ff @(posedge i_clk) begin
      if (state == tx_idle && i_tx_start)        tx_shift <= i_tx_byte;
      else if (state == tx_send && bit_tick)    tx_shift <= {tx_shift[6:0], 1'b1};
   end

   //////////////////////////////////////////////////
   // line

   always_comb begin
      case (state)
         tx_start: o_tx = 1'b0;
         tx_send:  o_tx = tx_shift[7];
         default:  o_tx = 1'b1;
      endcase
   end

   assign o_tx_busy = (state != tx_idle);

endmodule

/* vlog.f */
+incdir+hdl
hdl/ice51_pkg.sv
hdl/ice51_uart_loader.sv
hdl/ice51_uart_tx.sv
hdl/ice51_sequencer.sv
hdl/ice51_datapath.sv
hdl/ice51_top.sv
bench/tb_clock.sv
bench/tb_ice51.sv
